/* bench/uartEchoTb.sv */
// Directed testbench for the UART echo path.
// Drives serial frames into rxd, decodes the echo on txd and checks the
// bytes, the flow control on ctsN and the sticky overflow flag.
// Stops at the first error; every wait on the DUT is bounded.

`default_nettype none

`include "uart_defs.svh"

module uartEchoTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int bitClocks  = `CLKS_PER_TICK * `TICKS_PER_BIT;  // 256
  localparam int echoLimit  = 24 * bitClocks;   // start bit search window
  localparam int quietLimit = 12 * bitClocks;   // no-echo window

  logic        clk_29_pll = 1'b0;
  logic        reset;
  logic        rxd;
  logic        ctsN;
  wire         txd;
  wire         overflow;
  logic [31:0] lfsrState = 32'hb1b5;
  bit          sending;                          // burst in flight, test 4

  uartEcho dut (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .rxd        (rxd),
    .ctsN       (ctsN),
    .txd        (txd),
    .overflow   (overflow)
  );

  always #4 clk_29_pll = ~clk_29_pll;            // 8 ns period

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // returns 1 ns past a rising edge where inputs change and outputs are read
  task automatic stepClocks(input int n);
    repeat (n) @(posedge clk_29_pll);
    #1;
  endtask

  task automatic failRun();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check(input string testName, input logic [7:0] expected,
                       input logic [7:0] actual);
    if (expected !== actual) begin
      $display("error %s: expected %02h, actual %02h", testName, expected, actual);
      failRun();
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] randomByte();
    logic [7:0] value;
    value = '0;
    for (int i = 0; i < 8; i++) begin
      lfsrState = nextLfsr(lfsrState);           // one step per bit
      value = {value[6:0], lfsrState[0]};
    end
    return value;
  endfunction

  task automatic applyReset();
    reset = 1'b0;
    rxd   = 1'b1;                                // line idle
    ctsN  = 1'b0;
    stepClocks(3);
    reset = 1'b1;
  endtask

  // one 8N1 frame with the stop bit forced low on badStop
  task automatic sendByte(input logic [7:0] value, input bit badStop);
    rxd = 1'b0;                                  // start
    stepClocks(bitClocks);
    for (int i = 0; i < `DATA_BITS; i++) begin
      rxd = value[i];                            // LSB first
      stepClocks(bitClocks);
    end
    rxd = !badStop;
    stepClocks(bitClocks);
    rxd = 1'b1;
  endtask

  task automatic waitTxFall(input int limit, output bit found);
    logic prev;
    prev  = txd;
    found = 1'b0;
    for (int i = 0; i < limit && !found; i++) begin
      stepClocks(1);
      if (prev && !txd) begin
        found = 1'b1;
      end
      prev = txd;
    end
  endtask

  // returns mid stop bit, so the next call sees a clean falling edge
  task automatic receiveByte(input string testName, output logic [7:0] data);
    bit         found;
    logic [7:0] bits;
    bits = '0;
    data = '0;
    waitTxFall(echoLimit, found);
    if (!found) begin
      $display("timeout in %s: no start bit seen on txd", testName);
      failRun();
    end else begin
      stepClocks(bitClocks / 2);                 // middle of start bit
      check(testName, 8'd0, 8'(txd));
      for (int i = 0; i < `DATA_BITS; i++) begin
        stepClocks(bitClocks);
        bits[i] = txd;
      end
      stepClocks(bitClocks);
      check(testName, 8'd1, 8'(txd));            // stop bit
      data = bits;
    end
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic resetStateTest();
    for (int i = 0; i < 1000; i++) begin
      stepClocks(1);
      check("reset state", 8'd1, 8'(txd));
      check("reset state", 8'd0, 8'(overflow));
    end
  endtask

  task automatic singleEchoTest();
    logic [7:0] sent;
    logic [7:0] got;
    for (int n = 0; n < 4; n++) begin
      sent = randomByte();
      fork
        sendByte(sent, 1'b0);
        receiveByte("single echo", got);
      join
      check("single echo", sent, got);
      stepClocks(2 * bitClocks);                 // let the echo settle
    end
  endtask

  task automatic burstTest();
    logic [7:0] sent [$];
    logic [7:0] got  [$];
    logic [7:0] value;
    for (int n = 0; n < 6; n++) begin
      sent.push_back(randomByte());
    end
    fork
      begin
        foreach (sent[i]) sendByte(sent[i], 1'b0);   // no idle gap
      end
      begin
        for (int n = 0; n < 6; n++) begin
          receiveByte("burst", value);
          got.push_back(value);
        end
      end
    join
    foreach (sent[i]) check("burst", sent[i], got[i]);
    check("burst", 8'd0, 8'(overflow));
  endtask

  task automatic flowControlTest();
    logic [7:0] sent [$];
    logic [7:0] value;
    bit         found;
    for (int n = 0; n < 10; n++) begin
      sent.push_back(randomByte());
    end
    ctsN    = 1'b1;                              // hold back the transmitter
    sending = 1'b1;
    fork
      begin
        foreach (sent[i]) sendByte(sent[i], 1'b0);
        sending = 1'b0;
      end
      while (sending) begin
        stepClocks(1);
        check("flow control", 8'd1, 8'(txd));    // line must stay idle
      end
    join
    ctsN = 1'b0;
    for (int n = 0; n < 8; n++) begin
      receiveByte("flow control", value);
      check("flow control", sent[n], value);
    end
    waitTxFall(quietLimit, found);               // bytes 9 and 10 are lost
    check("flow control", 8'd0, 8'(found));
    check("flow control", 8'd1, 8'(overflow));
  endtask

  task automatic framingErrorTest();
    logic [7:0] badByte;
    logic [7:0] goodByte;
    logic [7:0] got;
    badByte  = randomByte();
    goodByte = randomByte();
    if (goodByte == badByte) begin
      goodByte = ~goodByte;                      // keep the two apart
    end
    stepClocks(2 * bitClocks);                   // filter starts low after reset
    fork
      begin
        sendByte(badByte, 1'b1);
        stepClocks(2 * bitClocks);               // idle so the filter sees high
        sendByte(goodByte, 1'b0);
      end
      receiveByte("framing error", got);         // first echo must be the good one
    join
    check("framing error", goodByte, got);
  endtask

  // ----------------------------------------
  // sequence
  // ----------------------------------------
  initial begin
    applyReset();
    resetStateTest();
    singleEchoTest();
    burstTest();
    flowControlTest();
    applyReset();                                // fresh FIFO, overflow cleared
    framingErrorTest();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* design/echoBufferPkg.sv */
// Types that describe the echo buffer between receiver and transmitter.
// Used by scoped name from the FIFO.

`default_nettype none

`include "uart_defs.svh"

package echoBufferPkg;

  // read or write pointer, wraps naturally at FIFO_DEPTH
  typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifoPtr_t;

  // entry count, one bit wider so a full buffer fits
  typedef logic [$clog2(`FIFO_DEPTH):0] fifoCount_t;

endpackage

`default_nettype wire

/* design/echoFifo.sv */
// 8-entry first-word-fall-through byte FIFO for the echo path.
// Write side takes a push strobe with no back-pressure; a byte that does
// not fit is lost and sets a sticky overflow flag, cleared only by reset.
// Read side is valid/ready with the head byte shown combinationally.

`default_nettype none

`include "uart_defs.svh"

module echoFifo (
  input  wire                     clk_29_pll,
  input  wire                     reset,       // sync, active low
  input  wire                     push,
  input  wire uartLinePkg::dataByte_t pushData,
  output logic                    valid,       // not empty
  output uartLinePkg::dataByte_t  headData,
  input  wire                     ready,
  output logic                    overflow     // sticky
);

  localparam echoBufferPkg::fifoCount_t depth =
    echoBufferPkg::fifoCount_t'(`FIFO_DEPTH);

  uartLinePkg::dataByte_t    mem [`FIFO_DEPTH];
  echoBufferPkg::fifoPtr_t   wrPtr;
  echoBufferPkg::fifoPtr_t   rdPtr;
  echoBufferPkg::fifoCount_t count;
  logic                      full;
  logic                      pop;
  logic                      write;

  assign full     = (count == depth);
  assign valid    = (count != '0);
  assign pop      = valid && ready;
  assign write    = push && (!full || pop);  // a pop frees the slot this cycle
  assign headData = mem[rdPtr];              // fall-through head

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (write) begin
      mem[wrPtr] <= pushData;
    end
  end

  // ----------------------------------------
  // pointers, count, overflow
  // ----------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (write) begin
        wrPtr <= wrPtr + 1'b1;                // wraps at depth
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({write, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;              // idle or both
      endcase
      if (push && !write) begin
        overflow <= 1'b1;                     // byte lost
      end
    end
  end

  countInRange : assert property (
    @(posedge clk_29_pll) disable iff (!reset)
    count <= depth
  );

endmodule

`default_nettype wire

/* design/uartEcho.sv */
// Top level of the UART echo path.
// rxd bytes are buffered in the FIFO and sent back on txd.
// ctsN high holds back the transmitter; overflow marks lost bytes.

`default_nettype none

module uartEcho (
  input  wire   clk_29_pll,
  input  wire   reset,        // sync, active low
  input  wire   rxd,
  input  wire   ctsN,         // clear to send, active low
  output logic  txd,
  output logic  overflow      // sticky until reset
);

  // ----------------------------------------
  // receiver to FIFO
  // ----------------------------------------
  logic                   push;
  uartLinePkg::dataByte_t pushData;

  // FIFO to transmitter
  logic                   valid;
  logic                   ready;
  uartLinePkg::dataByte_t headData;

  uartReceiver receiver (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .rxd        (rxd),
    .push       (push),
    .pushData   (pushData)
  );

  echoFifo fifo (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .push       (push),
    .pushData   (pushData),
    .valid      (valid),
    .headData   (headData),
    .ready      (ready),
    .overflow   (overflow)
  );

  uartTransmitter transmitter (
    .clk_29_pll (clk_29_pll),
    .reset      (reset),
    .ctsN       (ctsN),       // only the transmitter sees flow control
    .valid      (valid),
    .headData   (headData),
    .ready      (ready),
    .txd        (txd)
  );

endmodule

`default_nettype wire

/* design/uartLinePkg.sv */
// Types that describe the serial line side of the echo path.
// Used by scoped name from the receiver, transmitter and top level.

`default_nettype none

`include "uart_defs.svh"

package uartLinePkg;

  // ----------------------------------------
  // payload
  // ----------------------------------------
  typedef logic [`DATA_BITS-1:0] dataByte_t;      // one data byte

  // ----------------------------------------
  // timing counters
  // ----------------------------------------

  // clock prescaler, counts clocks up to one oversample tick
  typedef logic [$clog2(`CLKS_PER_TICK)-1:0] tickCount_t;

  // frame position
  // upper nibble is the bit slot (0 start, 1..8 data, 9 stop)
  // lower nibble is the tick inside that bit
  typedef logic [7:0] bitCount_t;

endpackage

`default_nettype wire

/* design/uartReceiver.sv */
// UART receiver on a 16x oversample tick.
// Filters the start edge, samples 8 data bits LSB first and checks the
// stop bit. A good byte is pushed with a one-cycle strobe; a byte whose
// stop bit reads 0 is dropped. No back-pressure on the push side.

`default_nettype none

`include "uart_defs.svh"

module uartReceiver (
  input  wire                     clk_29_pll,
  input  wire                     reset,       // sync, active low
  input  wire                     rxd,         // serial input, idle high
  output logic                    push,        // one-cycle byte strobe
  output uartLinePkg::dataByte_t  pushData     // valid with push
);

  localparam uartLinePkg::tickCount_t lastClk =
    uartLinePkg::tickCount_t'(`CLKS_PER_TICK - 1);
  localparam logic [3:0] samplePhase   = 4'(`SAMPLE_PHASE);
  localparam logic [3:0] lastDataSlot  = 4'(`DATA_BITS);
  localparam logic [3:0] stopSlot      = 4'(`DATA_BITS + 1);

  uartLinePkg::tickCount_t prescale;
  logic                    tick;
  logic [1:0]              rxdSync;       // metastability stages
  logic                    rxdLine;
  logic [3:0]              rxdFilter;     // bit 3 oldest
  logic                    startEdge;
  logic                    receiving;
  uartLinePkg::bitCount_t  frameCnt;
  logic [3:0]              slot;
  logic [3:0]              phase;
  logic                    sampleNow;
  uartLinePkg::dataByte_t  shiftReg;

  // ----------------------------------------
  // tick generation
  // ----------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      prescale <= '0;
    end else if (tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  assign tick = (prescale == lastClk);

  // ----------------------------------------
  // input sync and start filter
  // ----------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      rxdSync <= 2'b11;                          // line idles high
    end else begin
      rxdSync <= {rxdSync[0], rxd};
    end
  end

  assign rxdLine = rxdSync[1];

  // cleared to low so the line must be seen high before a start counts
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      rxdFilter <= '0;
    end else if (tick) begin
      rxdFilter <= {rxdFilter[2:0], rxdLine};
    end
  end

  assign startEdge = (rxdFilter == 4'b1100);    // two high then two low ticks

  // ----------------------------------------
  // frame counter and stop check
  // ----------------------------------------
  assign slot      = frameCnt[7:4];
  assign phase     = frameCnt[3:0];
  assign sampleNow = tick && receiving && (phase == samplePhase);

  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      receiving <= 1'b0;
      frameCnt  <= '0;
      push      <= 1'b0;
    end else begin
      push <= 1'b0;                              // strobe by default
      if (tick) begin
        if (!receiving) begin
          if (startEdge) begin
            receiving <= 1'b1;
            frameCnt  <= '0;
          end
        end else if (slot == stopSlot && phase == samplePhase + 4'd1) begin
          receiving <= 1'b0;                     // armed one tick after stop sample
        end else begin
          frameCnt <= frameCnt + 1'b1;
          if (sampleNow && slot == stopSlot) begin
            push <= rxdLine;                     // stop bit 0 drops the byte
          end
        end
      end
    end
  end

  // ----------------------------------------
  // data shift, LSB arrives first
  // ----------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (sampleNow && slot >= 4'd1 && slot <= lastDataSlot) begin
      shiftReg <= {rxdLine, shiftReg[`DATA_BITS-1:1]};
    end
  end

  assign pushData = shiftReg;

  // one byte per frame, the strobe must drop right away
  pushSingleCycle : assert property (
    @(posedge clk_29_pll) disable iff (!reset)
    push |=> !push
  );

endmodule

`default_nettype wire

/* design/uartTransmitter.sv */
// UART frame serializer with clear-to-send gating.
// Takes a byte from the FIFO on valid and ready, then sends start bit,
// 8 data bits LSB first and a stop bit at 256 clocks per bit.
// ready rises only when idle and ctsN is low; a running frame always ends.

`default_nettype none

`include "uart_defs.svh"

module uartTransmitter (
  input  wire                     clk_29_pll,
  input  wire                     reset,       // sync, active low
  input  wire                     ctsN,        // clear to send, active low
  input  wire                     valid,
  input  wire uartLinePkg::dataByte_t headData,
  output logic                    ready,
  output logic                    txd          // serial output, idle high
);

  localparam uartLinePkg::tickCount_t lastClk =
    uartLinePkg::tickCount_t'(`CLKS_PER_TICK - 1);
  localparam logic [3:0] samplePhase = 4'(`SAMPLE_PHASE);
  localparam logic [3:0] lastPhase   = 4'(`TICKS_PER_BIT - 1);
  localparam logic [3:0] stopSlot    = 4'(`DATA_BITS + 1);

  uartLinePkg::tickCount_t prescale;
  logic                    tick;
  logic                    accept;
  logic                    busy;
  uartLinePkg::bitCount_t  frameCnt;
  logic [3:0]              slot;
  logic [3:0]              phase;
  logic                    lineStep;
  uartLinePkg::dataByte_t  txReg;

  assign accept   = valid && ready;
  assign slot     = frameCnt[7:4];
  assign phase    = frameCnt[3:0];
  assign lineStep = tick && busy && (phase == samplePhase);

  // prescaler restarts on accept so frame timing is fixed to the handshake
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      prescale <= '0;
    end else if (accept || tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  assign tick = (prescale == lastClk);

  // ----------------------------------------
  // handshake
  // ----------------------------------------
  // registered, also acts as the sampling stage for the async ctsN pin
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      ready <= 1'b0;
    end else begin
      ready <= !ctsN && !busy && !accept;     // drops with the accepting edge
    end
  end

  // ----------------------------------------
  // frame sequencing
  // ----------------------------------------
  always_ff @(posedge clk_29_pll) begin
    if (!reset) begin
      busy     <= 1'b0;
      frameCnt <= '0;
      txd      <= 1'b1;
    end else if (accept) begin
      busy     <= 1'b1;
      frameCnt <= '0;
    end else if (tick && busy) begin
      if (lineStep) begin
        txd <= (slot == 4'd0) ? 1'b0 : txReg[0];   // start bit, then data/stop
      end
      if (slot == stopSlot && phase == lastPhase) begin
        busy <= 1'b0;                          // end of slot 9
      end else begin
        frameCnt <= frameCnt + 1'b1;
      end
    end
  end

  // shift in ones so slot 9 reads the stop bit
  always_ff @(posedge clk_29_pll) begin
    if (accept) begin
      txReg <= headData;
    end else if (lineStep && slot != 4'd0) begin
      txReg <= {1'b1, txReg[`DATA_BITS-1:1]};
    end
  end

  // registered ready must already be low once a frame runs
  noAcceptWhileBusy : assert property (
    @(posedge clk_29_pll) disable iff (!reset)
    accept |-> !busy
  );

endmodule

`default_nettype wire

/* include/uart_defs.svh */
// Line format and buffer size constants for the UART echo path.
// Included by the packages, the RTL modules and the testbench.
// Frame is 1 start bit, DATA_BITS data bits, no parity, 1 stop bit.

`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// ----------------------------------------
// serial line format
// ----------------------------------------
`define DATA_BITS      8     // data bits per frame, LSB first

// 29.49 MHz / 16 = 1.8432 MHz oversample tick
`define CLKS_PER_TICK  16
`define TICKS_PER_BIT  16    // 16 ticks per bit, 256 clocks per bit

// tick within a bit where rx samples and tx changes the line
`define SAMPLE_PHASE   2

// ----------------------------------------
// echo buffer
// ----------------------------------------
`define FIFO_DEPTH     8     // entries, power of two so pointers wrap

`endif

/* run.sh */
#!/bin/sh
# Build the UART echo testbench with Verilator and run it.
# Exit status is 0 only when the simulation reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module uartEchoTb \
  -o uartEchoSim

# a failing run stops via $fatal, keep its output for the search below
output=$(./obj_dir/uartEchoSim 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF '** PASS **'; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* sources.f */
+incdir+include
design/uartLinePkg.sv
design/echoBufferPkg.sv
design/uartReceiver.sv
design/echoFifo.sv
design/uartTransmitter.sv
design/uartEcho.sv
bench/uartEchoTb.sv
